// ==== hdl/meteo_pkg.sv ====
`default_nettype none

package meteo_pkg;

	// conversion sequencer states, one pass per converted word
	typedef enum logic [2:0] {
		mux_on,
		settle,
		start_conv,
		wait_eoc,
		advance,
		post_word,
		post_wait,
		wait_ready
	} acq_state_t;

	// byte dispatcher states
	typedef enum logic [1:0] {
		disp_idle,
		disp_fire,
		disp_wait_confirm,
		disp_finish
	} disp_state_t;

	// link controller states
	typedef enum logic [1:0] {
		link_idle,
		link_load,
		link_send,
		link_wait_end
	} link_state_t;

	// next bit position of the serializer
	// data bits go out msb first
	typedef enum logic [3:0] {
		start_bit,
		bit7,
		bit6,
		bit5,
		bit4,
		bit3,
		bit2,
		bit1,
		bit0,
		stop_bit
	} tx_bit_t;

endpackage

`default_nettype wire

// ==== hdl/acquisition_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module acquisition_sequencer #(
	parameter int unsigned num_channels = 8
) (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       eoc,
	input  logic       dispatch_busy,
	output logic       mux_en,
	output logic       soc,
	output logic       load_dato,
	output logic [3:0] canale,
	output logic       word_ready
);
	import meteo_pkg::*;

	// highest channel number before wrapping back to 0
	localparam logic [3:0] last_channel = 4'(num_channels - 1);

	acq_state_t state;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state      <= mux_on;
			mux_en     <= 1'b0;
			soc        <= 1'b0;
			load_dato  <= 1'b0;
			canale     <= 4'd0;
			word_ready <= 1'b0;
		end else begin
			case (state)
				// select the analog input first
				mux_on: begin
					mux_en <= 1'b1;
					state  <= settle;
				end
				// one idle cycle for the mux to settle
				settle: begin
					state <= start_conv;
				end
				start_conv: begin
					soc   <= 1'b1;
					state <= wait_eoc;
				end
				// converter busy while eoc is high
				wait_eoc: begin
					if (!eoc) begin
						load_dato <= 1'b1;
						mux_en    <= 1'b0;
						state     <= advance;
					end
				end
				// result loaded, close the conversion and step the channel
				advance: begin
					load_dato <= 1'b0;
					soc       <= 1'b0;
					if (canale == last_channel) begin
						canale <= 4'd0;
					end else begin
						canale <= canale + 4'd1;
					end
					state <= post_word;
				end
				// hand the word over to the dispatcher
				post_word: begin
					word_ready <= 1'b1;
					state      <= post_wait;
				end
				// dispatcher needs a cycle to raise busy
				post_wait: begin
					state <= wait_ready;
				end
				// both bytes confirmed once busy is seen low
				wait_ready: begin
					if (!dispatch_busy) begin
						word_ready <= 1'b0;
						state      <= mux_on;
					end
				end
				default: begin
					state <= mux_on;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/word_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_dispatcher (
	input  logic clock,
	input  logic rst_n,
	input  logic word_ready,
	input  logic confirm,
	output logic dispatch_busy,
	output logic shot,
	output logic add_mpx2
);
	import meteo_pkg::*;

	disp_state_t state;
	// set once the low byte has been confirmed
	logic        second_byte;

	// upper mux address follows the byte being sent
	assign add_mpx2 = second_byte;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state         <= disp_idle;
			dispatch_busy <= 1'b0;
			shot          <= 1'b0;
			second_byte   <= 1'b0;
		end else begin
			case (state)
				disp_idle: begin
					if (word_ready) begin
						dispatch_busy <= 1'b1;
						second_byte   <= 1'b0;
						state         <= disp_fire;
					end
				end
				// one cycle request to the link controller
				disp_fire: begin
					shot  <= 1'b1;
					state <= disp_wait_confirm;
				end
				disp_wait_confirm: begin
					shot <= 1'b0;
					if (confirm) begin
						if (!second_byte) begin
							// low byte out, go again for the high byte
							second_byte <= 1'b1;
							state       <= disp_fire;
						end else begin
							second_byte   <= 1'b0;
							dispatch_busy <= 1'b0;
							state         <= disp_finish;
						end
					end
				end
				// word_ready is still high for a cycle after busy drops
				disp_finish: begin
					if (!word_ready) begin
						state <= disp_idle;
					end
				end
				default: begin
					state <= disp_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/link_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_controller (
	input  logic clock,
	input  logic rst_n,
	input  logic shot,
	input  logic done,
	output logic load,
	output logic send,
	output logic confirm
);
	import meteo_pkg::*;

	link_state_t state;

	// load, send and confirm each come from a different state
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= link_idle;
			load    <= 1'b0;
			send    <= 1'b0;
			confirm <= 1'b0;
		end else begin
			case (state)
				link_idle: begin
					confirm <= 1'b0;
					if (shot) begin
						load  <= 1'b1;
						state <= link_load;
					end
				end
				// byte is in the buffer, ask to transmit it
				link_load: begin
					load  <= 1'b0;
					send  <= 1'b1;
					state <= link_send;
				end
				link_send: begin
					send  <= 1'b0;
					state <= link_wait_end;
				end
				// done covers both a finished frame and a refused send
				link_wait_end: begin
					if (done) begin
						confirm <= 1'b1;
						state   <= link_idle;
					end
				end
				default: begin
					state <= link_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tx_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_buffer (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       load,
	input  logic       send,
	input  logic       dsr,
	input  logic [7:0] data_in,
	input  logic       tx_end,
	output logic [7:0] out_reg,
	output logic       send_en,
	output logic       done,
	output logic       error
);
	// buffer holds a byte not yet sent or refused
	logic full;

	// holding register
	always_ff @(posedge clock) begin
		if (load && !full) begin
			out_reg <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			full    <= 1'b0;
			send_en <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
		end else begin
			done <= 1'b0;
			// frame finished on the line
			if (tx_end) begin
				send_en <= 1'b0;
				full    <= 1'b0;
				done    <= 1'b1;
			end
			if (load) begin
				if (!full) begin
					full <= 1'b1;
				end else begin
					error <= 1'b1;
				end
			end
			if (send) begin
				if (full && dsr) begin
					error   <= 1'b0;
					send_en <= 1'b1;
				end else begin
					// refused, drop the byte and finish the transfer
					error <= 1'b1;
					full  <= 1'b0;
					done  <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/serial_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_transmitter #(
	parameter int unsigned bit_delay = 104
) (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       send_en,
	input  logic [7:0] out_reg,
	output logic       data_out,
	output logic       tx_end
);
	import meteo_pkg::*;

	localparam int unsigned cnt_w = (bit_delay > 2) ? $clog2(bit_delay) : 1;
	localparam logic [cnt_w-1:0] cnt_reload = cnt_w'(bit_delay - 1);

	logic [cnt_w-1:0] cnt;
	tx_bit_t          next_bit;
	logic             bit_value;

	// line level for the position about to go out
	always_comb begin
		case (next_bit)
			start_bit: bit_value = 1'b0;
			bit7:      bit_value = out_reg[7];
			bit6:      bit_value = out_reg[6];
			bit5:      bit_value = out_reg[5];
			bit4:      bit_value = out_reg[4];
			bit3:      bit_value = out_reg[3];
			bit2:      bit_value = out_reg[2];
			bit1:      bit_value = out_reg[1];
			bit0:      bit_value = out_reg[0];
			default:   bit_value = 1'b1;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			cnt      <= '0;
			next_bit <= start_bit;
			data_out <= 1'b1;
			tx_end   <= 1'b0;
		end else if (!send_en || tx_end) begin
			// idle between frames, line high
			cnt      <= '0;
			next_bit <= start_bit;
			data_out <= 1'b1;
			tx_end   <= 1'b0;
		end else if (cnt == '0) begin
			// bit period over, put the next bit on the line
			data_out <= bit_value;
			cnt      <= cnt_reload;
			if (next_bit == stop_bit) begin
				next_bit <= start_bit;
			end else begin
				next_bit <= tx_bit_t'(next_bit + 4'd1);
			end
		end else begin
			cnt <= cnt - 1'b1;
			// start_bit as next position means the stop bit is on the line
			tx_end <= (cnt == cnt_w'(1)) && (next_bit == start_bit);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/meteo_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module meteo_interface #(
	parameter int unsigned bit_delay    = 104,
	parameter int unsigned num_channels = 8
) (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       eoc,
	input  logic [7:0] data_in,
	input  logic       dsr,
	output logic       soc,
	output logic       load_dato,
	output logic       add_mpx2,
	output logic [3:0] canale,
	output logic       mux_en,
	output logic       error,
	output logic       data_out
);
	// sequencer to dispatcher
	logic       word_ready;
	logic       dispatch_busy;
	// dispatcher to link controller
	logic       shot;
	logic       confirm;
	// link controller to buffer
	logic       load;
	logic       send;
	logic       done;
	// buffer to transmitter
	logic [7:0] out_reg;
	logic       send_en;
	logic       tx_end;

	acquisition_sequencer #(
		.num_channels(num_channels)
	) i_sequencer (
		.clock(clock),
		.rst_n(rst_n),
		.eoc(eoc),
		.dispatch_busy(dispatch_busy),
		.mux_en(mux_en),
		.soc(soc),
		.load_dato(load_dato),
		.canale(canale),
		.word_ready(word_ready)
	);

	word_dispatcher i_dispatcher (
		.clock(clock),
		.rst_n(rst_n),
		.word_ready(word_ready),
		.confirm(confirm),
		.dispatch_busy(dispatch_busy),
		.shot(shot),
		.add_mpx2(add_mpx2)
	);

	link_controller i_link (
		.clock(clock),
		.rst_n(rst_n),
		.shot(shot),
		.done(done),
		.load(load),
		.send(send),
		.confirm(confirm)
	);

	tx_buffer i_buffer (
		.clock(clock),
		.rst_n(rst_n),
		.load(load),
		.send(send),
		.dsr(dsr),
		.data_in(data_in),
		.tx_end(tx_end),
		.out_reg(out_reg),
		.send_en(send_en),
		.done(done),
		.error(error)
	);

	serial_transmitter #(
		.bit_delay(bit_delay)
	) i_transmitter (
		.clock(clock),
		.rst_n(rst_n),
		.send_en(send_en),
		.out_reg(out_reg),
		.data_out(data_out),
		.tx_end(tx_end)
	);

endmodule

`default_nettype wire

// ==== verification/meteo_interface_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module meteo_interface_assert #(
	parameter int unsigned num_channels = 8
) (
	input logic       clock,
	input logic       rst_n,
	input logic       load,
	input logic       send,
	input logic       confirm,
	input logic       shot,
	input logic       dispatch_busy,
	input logic       send_en,
	input logic       error,
	input logic [3:0] canale,
	input logic       tx_end
);

	// number of failed assertions
	int unsigned fail_count = 0;

	// link controller strobes come from separate states
	strobes_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({load, send, confirm}))
		else begin
			$error("load, send and confirm active together");
			fail_count++;
		end

	// a byte request belongs to a word in progress
	shot_in_word: assert property (@(posedge clock) disable iff (!rst_n)
		shot |-> dispatch_busy)
		else begin
			$error("shot outside a busy dispatch");
			fail_count++;
		end

	// accepted send clears the error flag
	no_send_on_error: assert property (@(posedge clock) disable iff (!rst_n)
		!(send_en && error))
		else begin
			$error("send_en high while error is set");
			fail_count++;
		end

	channel_range: assert property (@(posedge clock) disable iff (!rst_n)
		canale < num_channels)
		else begin
			$error("canale out of range");
			fail_count++;
		end

	// end of frame only while a frame is enabled
	tx_end_in_frame: assert property (@(posedge clock) disable iff (!rst_n)
		tx_end |-> send_en)
		else begin
			$error("tx_end without send_en");
			fail_count++;
		end

endmodule

bind meteo_interface meteo_interface_assert #(
	.num_channels(num_channels)
) i_assert (
	.clock(clock),
	.rst_n(rst_n),
	.load(load),
	.send(send),
	.confirm(confirm),
	.shot(shot),
	.dispatch_busy(dispatch_busy),
	.send_en(send_en),
	.error(error),
	.canale(canale),
	.tx_end(tx_end)
);

`default_nettype wire

// ==== verification/meteo_interface_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module meteo_interface_tb;

	localparam int bit_delay    = 8;
	localparam int num_channels = 8;
	localparam int num_words    = 20;
	// dsr held low for this word only
	localparam int refused_word = 10;
	localparam int word_timeout = 3000;
	localparam int gap_timeout  = 4000;

	localparam int t_reset     = 0;
	localparam int t_handshake = 1;
	localparam int t_channel   = 2;
	localparam int t_frame     = 3;
	localparam int t_refused   = 4;
	localparam int t_recovery  = 5;
	localparam int num_tests   = 6;

	logic       clock;
	logic       rst_n;
	logic       eoc;
	logic [7:0] data_in;
	logic       dsr;
	logic       soc;
	logic       load_dato;
	logic       add_mpx2;
	logic [3:0] canale;
	logic       mux_en;
	logic       error;
	logic       data_out;

	string test_names [num_tests] = '{"reset", "handshake", "channel_order",
		"frame_content", "refused_send", "recovery"};
	int    test_errors [num_tests];
	bit    timed_out;

	// progress counters shared between the processes
	int word_count;
	int channel_checks;
	int frames_received;
	int frames_compared;

	// decoded frames with the start bit in bit 0 and the stop bit in bit 9
	logic [9:0] frame_bits [$];
	bit         frame_stable [$];
	logic       frame_error [$];

	logic [31:0] rng_state;

	// conversion monitor state
	logic mon_soc_prev;
	logic mon_load_prev;
	logic eoc_seen_high;
	int   load_pulses;

	// converter and data model state
	logic        conv_soc_prev;
	int          eoc_left;
	logic        data_soc_prev;
	int unsigned data_word;

	meteo_interface #(
		.bit_delay(bit_delay),
		.num_channels(num_channels)
	) i_dut (
		.clock(clock),
		.rst_n(rst_n),
		.eoc(eoc),
		.data_in(data_in),
		.dsr(dsr),
		.soc(soc),
		.load_dato(load_dato),
		.add_mpx2(add_mpx2),
		.canale(canale),
		.mux_en(mux_en),
		.error(error),
		.data_out(data_out)
	);

	always begin
		#50 clock = ~clock;
	end

	function automatic logic [31:0] next_random(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// byte placed on the converter data bus for a word, channel and half
	function automatic logic [7:0] expected_byte(input int unsigned word_index,
			input logic [3:0] channel, input logic upper);
		logic [7:0] value;
		value = 8'(word_index * 29 + 7) ^ {channel, ~channel};
		if (upper)
			value = ~value;
		return value;
	endfunction

	// channels run 1 up to num_channels-1, then 0
	function automatic logic [3:0] channel_for_word(input int unsigned word_index);
		return 4'(word_index % num_channels);
	endfunction

	task automatic report_mismatch(input int test, input string msg);
		$display("ERR @ %0t ns: %s", $time, msg);
		test_errors[test]++;
	endtask

	task automatic report_problem(input int test, input string msg);
		$display("%s", msg);
		test_errors[test]++;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
	endtask

	task automatic print_test_result(input int test);
		$display("test %-14s %s, %0d failed checks", test_names[test],
			(test_errors[test] == 0) ? "passed" : "failed", test_errors[test]);
	endtask

	task automatic check_reset_values(input bit in_reset);
		if (soc !== 1'b0)
			report_mismatch(t_reset, $sformatf("soc is %b after reset", soc));
		if (load_dato !== 1'b0)
			report_mismatch(t_reset, $sformatf("load_dato is %b after reset", load_dato));
		if (add_mpx2 !== 1'b0)
			report_mismatch(t_reset, $sformatf("add_mpx2 is %b after reset", add_mpx2));
		if (error !== 1'b0)
			report_mismatch(t_reset, $sformatf("error is %b after reset", error));
		if (data_out !== 1'b1)
			report_mismatch(t_reset, $sformatf("data_out is %b after reset", data_out));
		if (canale !== 4'd0)
			report_mismatch(t_reset, $sformatf("canale is %h after reset", canale));
		// mux_en rises on the first clock after release
		if (in_reset && mux_en !== 1'b0)
			report_mismatch(t_reset, $sformatf("mux_en is %b in reset", mux_en));
	endtask

	task automatic wait_for_word(input int target, output bit ok);
		int cycles;
		ok = 1'b0;
		cycles = 0;
		while (!ok && !timed_out && cycles < word_timeout) begin
			@(negedge clock);
			cycles++;
			if (word_count == target)
				ok = 1'b1;
		end
		if (!ok && !timed_out)
			report_timeout($sformatf("conversion %0d never started", target));
	endtask

	// converter model holding eoc high for 1 to 6 cycles after soc rises
	always @(negedge clock) begin
		if (!rst_n) begin
			eoc           <= 1'b0;
			eoc_left      <= 0;
			conv_soc_prev <= 1'b0;
		end else begin
			if (soc && !conv_soc_prev) begin
				rng_state = next_random(rng_state);
				eoc      <= 1'b1;
				eoc_left <= int'(rng_state % 6) + 1;
			end else if (eoc_left > 0) begin
				if (eoc_left == 1)
					eoc <= 1'b0;
				eoc_left <= eoc_left - 1;
			end
			conv_soc_prev <= soc;
		end
	end

	// data model where the multiplexer address selects the byte
	always @(negedge clock) begin
		if (!rst_n) begin
			data_word     = 0;
			data_soc_prev = 1'b0;
		end else begin
			if (soc && !data_soc_prev)
				data_word = data_word + 1;
			data_soc_prev = soc;
		end
		data_in <= expected_byte(data_word, canale, add_mpx2);
	end

	// conversion handshake and channel order
	always @(negedge clock) begin
		if (!rst_n) begin
			mon_soc_prev  <= 1'b0;
			mon_load_prev <= 1'b0;
			eoc_seen_high <= 1'b0;
			load_pulses   <= 0;
		end else begin
			if (soc && !mon_soc_prev) begin
				word_count    <= word_count + 1;
				load_pulses   <= 0;
				eoc_seen_high <= 1'b0;
				if (mux_en !== 1'b1)
					report_mismatch(t_handshake, "mux_en low when soc rose");
			end else if (soc && eoc) begin
				eoc_seen_high <= 1'b1;
			end
			if (load_dato) begin
				if (!mon_load_prev)
					load_pulses <= load_pulses + 1;
				else
					report_mismatch(t_handshake, "load_dato high for more than one cycle");
				if (soc !== 1'b1)
					report_mismatch(t_handshake, "load_dato while soc is low");
				if (eoc !== 1'b0 || !eoc_seen_high)
					report_mismatch(t_handshake, "load_dato before eoc fell");
			end
			if (!soc && mon_soc_prev && load_pulses != 1)
				report_mismatch(t_handshake,
					$sformatf("%0d load_dato pulses in one conversion", load_pulses));
			// channel has advanced when load_dato drops
			if (!load_dato && mon_load_prev) begin
				channel_checks <= channel_checks + 1;
				if (canale !== channel_for_word(word_count))
					report_mismatch(t_channel, $sformatf("conversion %0d canale %h, expected %h",
						word_count, canale, channel_for_word(word_count)));
			end
			mon_soc_prev  <= soc;
			mon_load_prev <= load_dato;
		end
	end

	// frame decoder sampling every cycle of each bit
	initial begin : frame_decoder
		logic       last_level;
		logic       level;
		logic [9:0] bits;
		bit         stable;
		logic       error_at_start;
		bit         found;
		int         idle_cycles;
		int         b;
		int         s;
		last_level = 1'b1;
		while (!timed_out) begin
			found = 1'b0;
			idle_cycles = 0;
			while (!found && !timed_out && idle_cycles < gap_timeout) begin
				@(negedge clock);
				idle_cycles++;
				if (rst_n && last_level === 1'b1 && data_out === 1'b0)
					found = 1'b1;
				else
					last_level = data_out;
			end
			if (!found) begin
				if (!timed_out)
					report_timeout("no start bit seen on data_out");
			end else begin
				error_at_start = error;
				stable = 1'b1;
				for (b = 0; b < 10; b++) begin
					for (s = 0; s < bit_delay; s++) begin
						if (b != 0 || s != 0)
							@(negedge clock);
						if (s == 0)
							level = data_out;
						else if (data_out !== level)
							stable = 1'b0;
						// mid-bit sample
						if (s == bit_delay / 2)
							bits[b] = data_out;
					end
				end
				frame_bits.push_back(bits);
				frame_stable.push_back(stable);
				frame_error.push_back(error_at_start);
				frames_received <= frames_received + 1;
				last_level = data_out;
			end
		end
	end

	// compares each decoded frame with the reference byte
	initial begin : frame_checker
		int unsigned word;
		logic        upper;
		logic [9:0]  bits;
		logic [7:0]  data;
		logic [7:0]  want;
		bit          stable;
		logic        err_flag;
		int          test;
		int          waited;
		word = 1;
		upper = 1'b0;
		while (!timed_out) begin
			waited = 0;
			while (frame_bits.size() == 0 && !timed_out && waited < gap_timeout) begin
				@(negedge clock);
				waited++;
			end
			if (frame_bits.size() == 0) begin
				if (!timed_out)
					report_timeout("no frame reached the checker");
			end else begin
				// the refused word sends nothing
				if (word == refused_word)
					word++;
				bits = frame_bits.pop_front();
				stable = frame_stable.pop_front();
				err_flag = frame_error.pop_front();
				test = (word == refused_word + 1) ? t_recovery : t_frame;
				data = {bits[1], bits[2], bits[3], bits[4], bits[5], bits[6], bits[7], bits[8]};
				want = expected_byte(word, channel_for_word(word), upper);
				if (bits[0] !== 1'b0)
					report_mismatch(test, $sformatf("word %0d start bit is %b", word, bits[0]));
				if (bits[9] !== 1'b1)
					report_mismatch(test, $sformatf("word %0d stop bit is %b", word, bits[9]));
				if (!stable)
					report_mismatch(test, $sformatf("word %0d bit not held for %0d cycles",
						word, bit_delay));
				if (data !== want)
					report_mismatch(test, $sformatf("word %0d %s byte is %h, expected %h",
						word, upper ? "high" : "low", data, want));
				if (err_flag !== 1'b0)
					report_mismatch(test, $sformatf("word %0d sent with error set", word));
				frames_compared++;
				if (upper)
					word++;
				upper = !upper;
			end
		end
	end

	initial begin : main_sequence
		int  w;
		int  cycles;
		int  expected_frames;
		int  failed_tests;
		int  total_errors;
		int  assert_failures;
		bit  ok;
		clock = 1'b0;
		rst_n = 1'b0;
		eoc = 1'b0;
		data_in = 8'h00;
		dsr = 1'b1;
		rng_state = 32'h1aeb0a0d;

		// five clock cycles in reset
		for (cycles = 0; cycles < 5; cycles++) begin
			@(negedge clock);
			check_reset_values(1'b1);
		end
		rst_n <= 1'b1;
		@(negedge clock);
		check_reset_values(1'b0);
		print_test_result(t_reset);

		// first soc is due 3 cycles after release
		cycles = 1;
		while (soc !== 1'b1 && cycles < 20) begin
			@(negedge clock);
			cycles++;
		end
		if (soc !== 1'b1)
			report_timeout("soc never rose after reset");
		else if (cycles != 3)
			report_mismatch(t_handshake, $sformatf("first soc %0d cycles after reset", cycles));

		for (w = 1; w <= num_words && !timed_out; w++) begin
			dsr <= (w != refused_word);
			wait_for_word(w + 1, ok);
			if (!ok)
				break;
			// both bytes are out before the next conversion starts
			expected_frames = 2 * w - ((w >= refused_word) ? 2 : 0);
			if (frames_received != expected_frames)
				report_mismatch((w == refused_word) ? t_refused : t_frame,
					$sformatf("%0d frames after word %0d, expected %0d",
						frames_received, w, expected_frames));
			if (w == refused_word) begin
				if (error !== 1'b1)
					report_mismatch(t_refused, "error not raised by refused send");
				print_test_result(t_refused);
			end
			if (w == refused_word + 1) begin
				if (error !== 1'b0)
					report_mismatch(t_recovery, "error still set after accepted send");
				print_test_result(t_recovery);
			end
		end

		cycles = 0;
		while (!timed_out && frames_compared != frames_received && cycles < 50) begin
			@(negedge clock);
			cycles++;
		end
		if (frames_compared != frames_received && !timed_out)
			report_timeout("checker fell behind the decoder");
		if (channel_checks < num_words)
			report_problem(t_channel,
				$sformatf("only %0d channel values were seen", channel_checks));
		if (frames_compared == 0)
			report_problem(t_frame, "no frame was checked");
		print_test_result(t_handshake);
		print_test_result(t_channel);
		print_test_result(t_frame);

		failed_tests = 0;
		total_errors = 0;
		for (w = 0; w < num_tests; w++) begin
			total_errors += test_errors[w];
			if (test_errors[w] != 0)
				failed_tests++;
		end
		// concurrent checks bound into the DUT
		assert_failures = i_dut.i_assert.fail_count;
		$display("tests: %0d run, %0d failed; failed checks: %0d; %s: %0d; frames checked: %0d",
			num_tests, failed_tests, total_errors, "assertion failures", assert_failures,
			frames_compared);
		if (total_errors == 0 && assert_failures == 0 && !timed_out) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/meteo_pkg.sv
hdl/acquisition_sequencer.sv
hdl/word_dispatcher.sv
hdl/link_controller.sv
hdl/tx_buffer.sv
hdl/serial_transmitter.sv
hdl/meteo_interface.sv
verification/meteo_interface_assert.sv
verification/meteo_interface_tb.sv
